// File: exe_pkg.sv
`default_nettype none

package exe_pkg;

	localparam int unsigned xlen = 32; // Default data and address width

	typedef enum logic [5:0] {
		op_add,
		op_sub,
		op_sll,
		op_slt,
		op_sltu,
		op_xor,
		op_srl,
		op_sra,
		op_or,
		op_and,
		op_lui,
		op_auipc,
		op_jal,
		op_jalr,
		op_beq,
		op_bne,
		op_blt,
		op_bge,
		op_bltu,
		op_bgeu,
		op_mul,
		op_mulh,
		op_mulhu,
		op_div,
		op_divu,
		op_rem,
		op_remu,
		op_lb,
		op_lh,
		op_lw,
		op_lbu,
		op_lhu,
		op_sb,
		op_sh,
		op_sw
	} exe_op_e;

	typedef enum logic [1:0] {
		unit_alu,
		unit_muldiv,
		unit_lsu
	} exe_unit_e;

	typedef enum logic [1:0] {
		st_idle,
		st_wait_muldiv,
		st_wait_lsu
	} exe_ctrl_state_e;

	typedef struct packed {
		exe_op_e          op;
		logic [4:0]       rd;
		logic             we;
		logic [xlen-1:0]  op_a;
		logic [xlen-1:0]  op_b; // rs2, immediate for I-type, or store data
		logic [xlen-1:0]  imm;
		logic [xlen-1:0]  pc;
	} exe_issue_t;

	typedef struct packed {
		logic [4:0]       rd;
		logic             we;
		logic [xlen-1:0]  data;
		logic             misaligned;
	} exe_wb_t;

	typedef struct packed {
		logic             taken;
		logic [xlen-1:0]  target;
	} exe_redirect_t;

	// Wishbone classic master outputs
	typedef struct packed {
		logic             cyc;
		logic             stb;
		logic             we;
		logic [3:0]       sel;
		logic [xlen-1:0]  adr;
		logic [xlen-1:0]  dat;
	} exe_wb_req_t;

endpackage

`default_nettype wire

// File: exe_alu.sv
`default_nettype none

module exe_alu #(
	parameter int unsigned XLEN = exe_pkg::xlen
) (
	input  exe_pkg::exe_issue_t    issue,
	output logic [XLEN-1:0]        result,
	output exe_pkg::exe_redirect_t redirect
);

	logic [XLEN-1:0] a, b;
	logic [4:0]      shamt;
	logic            eq, lt, ltu;
	logic            taken;
	logic [XLEN-1:0] target;

	assign a     = issue.op_a;
	assign b     = issue.op_b;
	assign shamt = b[4:0];
	assign eq    = (a == b);
	assign lt    = ($signed(a) < $signed(b));
	assign ltu   = (a < b);

	always_comb begin
		case (issue.op)
			exe_pkg::op_add:   result = a + b;
			exe_pkg::op_sub:   result = a - b;
			exe_pkg::op_sll:   result = a << shamt;
			exe_pkg::op_slt:   result = {{(XLEN-1){1'b0}}, lt};
			exe_pkg::op_sltu:  result = {{(XLEN-1){1'b0}}, ltu};
			exe_pkg::op_xor:   result = a ^ b;
			exe_pkg::op_srl:   result = a >> shamt;
			exe_pkg::op_sra:   result = $unsigned($signed(a) >>> shamt);
			exe_pkg::op_or:    result = a | b;
			exe_pkg::op_and:   result = a & b;
			exe_pkg::op_lui:   result = issue.imm;
			exe_pkg::op_auipc: result = issue.pc + issue.imm;
			exe_pkg::op_jal,
			exe_pkg::op_jalr:  result = issue.pc + XLEN'(4); // Link address
			default:           result = '0;
		endcase
	end

	always_comb begin
		case (issue.op)
			exe_pkg::op_beq:  taken = eq;
			exe_pkg::op_bne:  taken = !eq;
			exe_pkg::op_blt:  taken = lt;
			exe_pkg::op_bge:  taken = !lt;
			exe_pkg::op_bltu: taken = ltu;
			exe_pkg::op_bgeu: taken = !ltu;
			exe_pkg::op_jal,
			exe_pkg::op_jalr: taken = 1'b1;
			default:          taken = 1'b0;
		endcase
	end

	// jalr is register relative and drops bit 0
	always_comb begin
		if (issue.op == exe_pkg::op_jalr)
			target = (a + issue.imm) & ~XLEN'(1);
		else
			target = issue.pc + issue.imm;
	end

	assign redirect = '{taken: taken, target: target};

endmodule

`default_nettype wire

// File: exe_muldiv.sv
`default_nettype none

module exe_muldiv #(
	parameter int unsigned XLEN = exe_pkg::xlen
) (
	input  wire              clk,
	input  wire              arst_n,
	input  wire              start,
	input  exe_pkg::exe_op_e op,
	input  wire [XLEN-1:0]   op_a,
	input  wire [XLEN-1:0]   op_b,
	output logic             done,
	output logic [XLEN-1:0]  result
);

	logic                   busy;
	logic [4:0]             cnt;
	exe_pkg::exe_op_e       op_q;
	logic                   div_q, neg_res, div_zero;
	logic [XLEN-1:0]        a_q;
	logic [XLEN-1:0]        acc, q, d; // Upper half or remainder, lower half or quotient, operand
	logic                   is_div, sgn;
	logic [XLEN-1:0]        mag_a, mag_b;
	logic [XLEN:0]          sum, shifted, diff;
	logic [2*XLEN-1:0]      prod, prod_s;
	logic [XLEN-1:0]        quo_s, rem_s;

	assign is_div = (op == exe_pkg::op_div) || (op == exe_pkg::op_divu) ||
		(op == exe_pkg::op_rem) || (op == exe_pkg::op_remu);
	assign sgn    = (op == exe_pkg::op_mulh) || (op == exe_pkg::op_div) ||
		(op == exe_pkg::op_rem);
	assign mag_a  = (sgn && op_a[XLEN-1]) ? -op_a : op_a;
	assign mag_b  = (sgn && op_b[XLEN-1]) ? -op_b : op_b;

	assign sum     = {1'b0, acc} + (q[0] ? {1'b0, d} : '0);
	assign shifted = {acc, q[XLEN-1]};
	assign diff    = shifted - {1'b0, d};

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy) begin
				cnt <= cnt + 5'd1;
				if (cnt == 5'd31) begin // Last of 32 steps
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			op_q     <= op;
			div_q    <= is_div;
			a_q      <= op_a;
			div_zero <= (op_b == '0);
			neg_res  <= sgn && (op_a[XLEN-1] ^ (op_b[XLEN-1] && op != exe_pkg::op_rem));
			acc      <= '0;
			q        <= is_div ? mag_a : mag_b;
			d        <= is_div ? mag_b : mag_a;
		end else if (busy) begin
			if (!div_q) begin
				acc <= sum[XLEN:1];
				q   <= {sum[0], q[XLEN-1:1]};
			end else if (diff[XLEN]) begin
				acc <= shifted[XLEN-1:0];
				q   <= {q[XLEN-2:0], 1'b0};
			end else begin
				acc <= diff[XLEN-1:0];
				q   <= {q[XLEN-2:0], 1'b1};
			end
		end
	end

	// Overflow case needs no special path since negating the magnitude restores the dividend
	assign prod   = {acc, q};
	assign prod_s = neg_res ? -prod : prod;
	assign quo_s  = neg_res ? -q : q;
	assign rem_s  = neg_res ? -acc : acc;

	always_comb begin
		case (op_q)
			exe_pkg::op_mul:   result = prod[XLEN-1:0];
			exe_pkg::op_mulh:  result = prod_s[2*XLEN-1:XLEN];
			exe_pkg::op_mulhu: result = prod[2*XLEN-1:XLEN];
			exe_pkg::op_div,
			exe_pkg::op_divu:  result = div_zero ? '1 : quo_s;
			exe_pkg::op_rem,
			exe_pkg::op_remu:  result = div_zero ? a_q : rem_s;
			default:           result = '0;
		endcase
	end

	a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
		start |-> !busy);

endmodule

`default_nettype wire

// File: exe_lsu.sv
`default_nettype none

module exe_lsu #(
	parameter int unsigned XLEN = exe_pkg::xlen
) (
	input  wire                  clk,
	input  wire                  arst_n,
	input  wire                  start,
	input  exe_pkg::exe_issue_t  issue,
	output logic                 done,
	output logic [XLEN-1:0]      result,
	output logic                 misaligned,
	output exe_pkg::exe_wb_req_t dmem_req,
	input  wire                  dmem_ack,
	input  wire [XLEN-1:0]       dmem_rdata
);

	logic [XLEN-1:0]  addr;
	logic             bad_align, is_store;
	logic [3:0]       sel;
	logic [XLEN-1:0]  wdata;
	logic             cyc_q, mis_q, we_q;
	logic [3:0]       sel_q;
	logic [XLEN-1:0]  adr_q, dat_q;
	exe_pkg::exe_op_e op_q;
	logic [1:0]       off_q;
	logic [XLEN-1:0]  lane, load_data;

	assign addr     = issue.op_a + issue.imm;
	assign is_store = (issue.op == exe_pkg::op_sb) || (issue.op == exe_pkg::op_sh) ||
		(issue.op == exe_pkg::op_sw);

	always_comb begin
		case (issue.op)
			exe_pkg::op_lb, exe_pkg::op_lbu, exe_pkg::op_sb: begin
				bad_align = 1'b0;
				sel       = 4'b0001 << addr[1:0];
				wdata     = {4{issue.op_b[7:0]}};
			end
			exe_pkg::op_lh, exe_pkg::op_lhu, exe_pkg::op_sh: begin
				bad_align = addr[0];
				sel       = 4'b0011 << addr[1:0];
				wdata     = {2{issue.op_b[15:0]}};
			end
			default: begin // Word access
				bad_align = |addr[1:0];
				sel       = 4'b1111;
				wdata     = issue.op_b;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cyc_q <= 1'b0;
			mis_q <= 1'b0;
		end else begin
			mis_q <= start & bad_align; // Misaligned never opens a bus cycle
			if (start && !bad_align)
				cyc_q <= 1'b1;
			else if (cyc_q && dmem_ack)
				cyc_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			op_q  <= issue.op;
			off_q <= addr[1:0];
			adr_q <= {addr[XLEN-1:2], 2'b00};
			sel_q <= sel;
			we_q  <= is_store;
			dat_q <= wdata;
		end
	end

	assign dmem_req = '{cyc: cyc_q, stb: cyc_q, we: we_q, sel: sel_q, adr: adr_q, dat: dat_q};

	assign lane = dmem_rdata >> {off_q, 3'b000};

	always_comb begin
		case (op_q)
			exe_pkg::op_lb:  load_data = {{(XLEN-8){lane[7]}}, lane[7:0]};
			exe_pkg::op_lbu: load_data = {{(XLEN-8){1'b0}}, lane[7:0]};
			exe_pkg::op_lh:  load_data = {{(XLEN-16){lane[15]}}, lane[15:0]};
			exe_pkg::op_lhu: load_data = {{(XLEN-16){1'b0}}, lane[15:0]};
			exe_pkg::op_lw:  load_data = lane;
			default:         load_data = '0;
		endcase
	end

	assign done       = mis_q | (cyc_q & dmem_ack); // Ack cycle so write-back follows directly
	assign result     = mis_q ? '0 : load_data;
	assign misaligned = mis_q;

	a_wb_hold: assert property (@(posedge clk) disable iff (!arst_n)
		(dmem_req.stb && !dmem_ack) |=> dmem_req.stb && $stable(dmem_req.adr) &&
		$stable(dmem_req.sel) && $stable(dmem_req.we) && $stable(dmem_req.dat));

endmodule

`default_nettype wire

// File: exe_ctrl.sv
`default_nettype none

module exe_ctrl #(
	parameter int unsigned XLEN = exe_pkg::xlen
) (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    issue_valid,
	input  exe_pkg::exe_issue_t    issue,
	output logic                   issue_ready,
	output exe_pkg::exe_issue_t    alu_issue,
	input  wire [XLEN-1:0]         alu_result,
	input  exe_pkg::exe_redirect_t alu_redirect,
	output logic                   md_start,
	input  wire                    md_done,
	input  wire [XLEN-1:0]         md_result,
	output logic                   lsu_start,
	input  wire                    lsu_done,
	input  wire [XLEN-1:0]         lsu_result,
	input  wire                    lsu_misaligned,
	output exe_pkg::exe_issue_t    unit_issue,
	output logic                   wb_valid,
	output exe_pkg::exe_wb_t       wb,
	output exe_pkg::exe_redirect_t redirect
);

	exe_pkg::exe_ctrl_state_e state, state_nxt;
	exe_pkg::exe_unit_e       unit;
	logic                     accept, alu_accept;
	logic                     taken_q;
	logic [XLEN-1:0]          target_q;
	exe_pkg::exe_wb_t         wb_q;
	logic [4:0]               pend_rd;
	logic                     pend_we;

	always_comb begin
		case (issue.op)
			exe_pkg::op_mul, exe_pkg::op_mulh, exe_pkg::op_mulhu, exe_pkg::op_div,
			exe_pkg::op_divu, exe_pkg::op_rem, exe_pkg::op_remu: unit = exe_pkg::unit_muldiv;
			exe_pkg::op_lb, exe_pkg::op_lh, exe_pkg::op_lw, exe_pkg::op_lbu,
			exe_pkg::op_lhu, exe_pkg::op_sb, exe_pkg::op_sh, exe_pkg::op_sw: unit = exe_pkg::unit_lsu;
			default: unit = exe_pkg::unit_alu;
		endcase
	end

	assign issue_ready = (state == exe_pkg::st_idle); // Long ops hold off issue until write-back
	assign accept      = issue_valid & issue_ready;
	assign alu_accept  = accept & (unit == exe_pkg::unit_alu);
	assign md_start    = accept & (unit == exe_pkg::unit_muldiv);
	assign lsu_start   = accept & (unit == exe_pkg::unit_lsu);
	assign alu_issue   = issue;
	assign unit_issue  = issue;

	always_comb begin
		state_nxt = state;
		case (state)
			exe_pkg::st_idle: begin
				if (md_start)
					state_nxt = exe_pkg::st_wait_muldiv;
				else if (lsu_start)
					state_nxt = exe_pkg::st_wait_lsu;
			end
			exe_pkg::st_wait_muldiv: if (md_done) state_nxt = exe_pkg::st_idle;
			exe_pkg::st_wait_lsu:    if (lsu_done) state_nxt = exe_pkg::st_idle;
			default:                 state_nxt = exe_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= exe_pkg::st_idle;
			wb_valid <= 1'b0;
			taken_q  <= 1'b0;
		end else begin
			state    <= state_nxt;
			wb_valid <= alu_accept | md_done | lsu_done;
			taken_q  <= alu_accept & alu_redirect.taken;
		end
	end

	always_ff @(posedge clk) begin
		if (md_start || lsu_start) begin
			pend_rd <= issue.rd; // Held so the long op retires with its own rd
			pend_we <= issue.we;
		end
		if (alu_accept) begin
			wb_q     <= '{rd: issue.rd, we: issue.we, data: alu_result, misaligned: 1'b0};
			target_q <= alu_redirect.target;
		end else if (md_done) begin
			wb_q <= '{rd: pend_rd, we: pend_we, data: md_result, misaligned: 1'b0};
		end else if (lsu_done) begin
			wb_q <= '{rd: pend_rd, we: pend_we & ~lsu_misaligned, data: lsu_result,
				misaligned: lsu_misaligned};
		end
	end

	assign wb       = wb_q;
	assign redirect = '{taken: taken_q, target: target_q};

	// A unit only finishes while the control waits for it, so no start slipped in elsewhere
	a_md_done_wait: assert property (@(posedge clk) disable iff (!arst_n)
		md_done |-> state == exe_pkg::st_wait_muldiv);

	a_lsu_done_wait: assert property (@(posedge clk) disable iff (!arst_n)
		lsu_done |-> state == exe_pkg::st_wait_lsu);

	a_one_done: assert property (@(posedge clk) disable iff (!arst_n)
		!(md_done && lsu_done));

endmodule

`default_nettype wire

// File: exe_stage.sv
`default_nettype none

module exe_stage #(
	parameter int unsigned XLEN = exe_pkg::xlen
) (
	input  wire                    clk,
	input  wire                    arst_n,
	input  wire                    issue_valid,
	input  exe_pkg::exe_issue_t    issue,
	output logic                   issue_ready,
	output logic                   wb_valid,
	output exe_pkg::exe_wb_t       wb,
	output exe_pkg::exe_redirect_t redirect,
	output exe_pkg::exe_wb_req_t   dmem_req,
	input  wire                    dmem_ack,
	input  wire [XLEN-1:0]         dmem_rdata
);

	exe_pkg::exe_issue_t    alu_issue;
	exe_pkg::exe_issue_t    unit_issue;
	logic [XLEN-1:0]        alu_result;
	exe_pkg::exe_redirect_t alu_redirect;
	logic                   md_start;
	logic                   md_done;
	logic [XLEN-1:0]        md_result;
	logic                   lsu_start;
	logic                   lsu_done;
	logic [XLEN-1:0]        lsu_result;
	logic                   lsu_misaligned;

	exe_ctrl #(.XLEN(XLEN)) u_ctrl (
		.clk            (clk),
		.arst_n         (arst_n),
		.issue_valid    (issue_valid),
		.issue          (issue),
		.issue_ready    (issue_ready),
		.alu_issue      (alu_issue),
		.alu_result     (alu_result),
		.alu_redirect   (alu_redirect),
		.md_start       (md_start),
		.md_done        (md_done),
		.md_result      (md_result),
		.lsu_start      (lsu_start),
		.lsu_done       (lsu_done),
		.lsu_result     (lsu_result),
		.lsu_misaligned (lsu_misaligned),
		.unit_issue     (unit_issue),
		.wb_valid       (wb_valid),
		.wb             (wb),
		.redirect       (redirect)
	);

	exe_alu #(.XLEN(XLEN)) u_alu (
		.issue    (alu_issue),
		.result   (alu_result),
		.redirect (alu_redirect)
	);

	exe_muldiv #(.XLEN(XLEN)) u_muldiv (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (md_start),
		.op     (unit_issue.op),
		.op_a   (unit_issue.op_a),
		.op_b   (unit_issue.op_b),
		.done   (md_done),
		.result (md_result)
	);

	exe_lsu #(.XLEN(XLEN)) u_lsu (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (lsu_start),
		.issue      (unit_issue),
		.done       (lsu_done),
		.result     (lsu_result),
		.misaligned (lsu_misaligned),
		.dmem_req   (dmem_req),
		.dmem_ack   (dmem_ack),
		.dmem_rdata (dmem_rdata)
	);

endmodule

`default_nettype wire

// File: tb_exe_checker.sv
`default_nettype none

module tb_exe_checker (
	input  wire                    clk,
	input  wire                    wb_valid,
	input  exe_pkg::exe_wb_t       wb,
	input  exe_pkg::exe_redirect_t redirect,
	output int                     n_seen,
	output int                     n_ok,
	output int                     n_bad
);

	timeunit 1ns;
	timeprecision 1ns;

	string       names[$];
	logic [4:0]  exp_rd[$];
	logic        exp_we[$];
	logic        exp_mis[$];
	logic        exp_taken[$];
	logic [31:0] exp_data[$];
	logic [31:0] exp_target[$];

	initial begin : load
		int          fd;
		int          n;
		string       line;
		string       name;
		logic [31:0] rd, we, a, b, imm, pc, d, m, t, tg;
		fd = $fopen("exe_trace.txt", "r");
		if (fd == 0)
			$display("Checker cannot open exe_trace.txt");
		while (fd != 0 && $fgets(line, fd)) begin
			if (line.len() < 3 || line[0] == "#")
				continue;
			n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h",
				name, rd, we, a, b, imm, pc, d, m, t, tg);
			if (n != 11) begin
				$display("Checker found a malformed trace line: %s", line);
				n_bad++;
				continue;
			end
			names.push_back(name);
			exp_rd.push_back(rd[4:0]);
			exp_we.push_back(we[0]);
			exp_data.push_back(d);
			exp_mis.push_back(m[0]);
			exp_taken.push_back(t[0]);
			exp_target.push_back(tg);
		end
		if (fd != 0)
			$fclose(fd);
	end

	task automatic check_one(input int i);
		int errs;
		errs = 0;
		if (wb.rd !== exp_rd[i]) begin
			$display("MISMATCH test %0d %s wb.rd got %h expected %h",
				i + 1, names[i], wb.rd, exp_rd[i]);
			errs++;
		end
		if (exp_we[i] && !exp_mis[i] && wb.data !== exp_data[i]) begin
			$display("MISMATCH test %0d %s wb.data got %h expected %h",
				i + 1, names[i], wb.data, exp_data[i]);
			errs++;
		end
		if (wb.we !== (exp_we[i] & ~exp_mis[i])) begin
			$display("MISMATCH test %0d %s wb.we got %h expected %h",
				i + 1, names[i], wb.we, exp_we[i] & ~exp_mis[i]);
			errs++;
		end
		if (wb.misaligned !== exp_mis[i]) begin
			$display("MISMATCH test %0d %s wb.misaligned got %h expected %h",
				i + 1, names[i], wb.misaligned, exp_mis[i]);
			errs++;
		end
		if (redirect.taken !== exp_taken[i]) begin
			$display("MISMATCH test %0d %s redirect.taken got %h expected %h",
				i + 1, names[i], redirect.taken, exp_taken[i]);
			errs++;
		end
		if (exp_taken[i] && redirect.target !== exp_target[i]) begin
			$display("MISMATCH test %0d %s redirect.target got %h expected %h",
				i + 1, names[i], redirect.target, exp_target[i]);
			errs++;
		end
		if (errs == 0) begin
			$display("test %0d %s ok", i + 1, names[i]);
			n_ok++;
		end else begin
			$display("test %0d %s has %0d errors", i + 1, names[i], errs);
			n_bad++;
		end
	endtask

	// Registered outputs are settled by the falling edge
	always @(negedge clk) begin
		if (wb_valid === 1'b1) begin
			if (n_seen >= names.size()) begin
				$display("Write-back for rd %0d arrived with no trace line left", wb.rd);
				n_bad++;
			end else begin
				check_one(n_seen);
			end
			n_seen++;
		end
	end

endmodule

`default_nettype wire

// File: tb_exe_stage.sv
`default_nettype none

module tb_exe_stage;

	timeunit 1ns;
	timeprecision 1ns;

	logic                   clk = 1'b0;
	logic                   arst_n;
	logic                   issue_valid;
	exe_pkg::exe_issue_t    issue;
	logic                   issue_ready;
	logic                   wb_valid;
	exe_pkg::exe_wb_t       wb;
	exe_pkg::exe_redirect_t redirect;
	exe_pkg::exe_wb_req_t   dmem_req;
	logic                   dmem_ack;
	logic [31:0]            dmem_rdata;

	exe_pkg::exe_issue_t issues[$];
	string               names[$];
	int                  trace_errs;
	logic                trace_loaded = 1'b0;
	int                  chk_seen;
	int                  chk_ok;
	int                  chk_bad;
	logic [31:0]         mem [0:63];
	logic [31:0]         lfsr = 32'hb3f9;
	logic [1:0]          wait_left;
	logic                pending = 1'b0;
	logic [5:0]          idx;

	always #50 clk = ~clk;

	exe_stage #(.XLEN(exe_pkg::xlen)) u_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.issue_valid (issue_valid),
		.issue       (issue),
		.issue_ready (issue_ready),
		.wb_valid    (wb_valid),
		.wb          (wb),
		.redirect    (redirect),
		.dmem_req    (dmem_req),
		.dmem_ack    (dmem_ack),
		.dmem_rdata  (dmem_rdata)
	);

	tb_exe_checker u_chk (
		.clk      (clk),
		.wb_valid (wb_valid),
		.wb       (wb),
		.redirect (redirect),
		.n_seen   (chk_seen),
		.n_ok     (chk_ok),
		.n_bad    (chk_bad)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic exe_pkg::exe_op_e op_from_name(input string name);
		exe_pkg::exe_op_e op;
		op = op.first();
		for (int i = 0; i < op.num(); i++) begin
			if (op.name() == {"op_", name})
				return op;
			op = op.next();
		end
		$display("Unknown opcode %s in trace", name);
		trace_errs++;
		return exe_pkg::op_add;
	endfunction

	task automatic read_trace();
		int                  fd;
		int                  n;
		string               line;
		string               name;
		logic [31:0]         rd, we, a, b, imm, pc;
		exe_pkg::exe_issue_t it;
		fd = $fopen("exe_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open exe_trace.txt");
			trace_errs++;
			return;
		end
		while ($fgets(line, fd)) begin
			if (line.len() < 3 || line[0] == "#")
				continue;
			it = '0;
			n = $sscanf(line, "%s %h %h %h %h %h %h", name, rd, we, a, b, imm, pc);
			if (n != 7) begin
				$display("Malformed trace line: %s", line);
				trace_errs++;
				continue;
			end
			it.op   = op_from_name(name);
			it.rd   = rd[4:0];
			it.we   = we[0];
			it.op_a = a;
			it.op_b = b;
			it.imm  = imm;
			it.pc   = pc;
			issues.push_back(it);
			names.push_back(name);
		end
		$fclose(fd);
	endtask

	// Wishbone slave, 0 to 3 wait states per cycle
	always @(negedge clk) begin
		if (!arst_n) begin
			dmem_ack = 1'b0;
			pending  = 1'b0;
		end else if (dmem_ack) begin
			dmem_ack = 1'b0;
		end else if (dmem_req.cyc && dmem_req.stb) begin
			if (!pending) begin
				for (int b = 0; b < 2; b++) begin
					lfsr         = lfsr_next(lfsr);
					wait_left[b] = lfsr[0];
				end
				pending = 1'b1;
			end
			if (wait_left == 2'd0) begin
				idx = dmem_req.adr[7:2];
				for (int k = 0; k < 4; k++)
					if (dmem_req.we && dmem_req.sel[k])
						mem[idx][8*k +: 8] = dmem_req.dat[8*k +: 8];
				dmem_rdata = mem[idx];
				dmem_ack   = 1'b1;
				pending    = 1'b0;
			end else begin
				wait_left = wait_left - 2'd1;
			end
		end
	end

	initial begin
		arst_n      = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		dmem_ack    = 1'b0;
		dmem_rdata  = '0;
		for (int i = 0; i < 64; i++)
			mem[i] = 32'hc0de_0000 | (i * 32'h0000_0401);
		read_trace();
		trace_loaded = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		foreach (issues[i]) begin
			issue_valid = 1'b1;
			issue       = issues[i];
			while (!issue_ready) // Ready only moves on rising edges
				@(negedge clk);
			@(negedge clk);
		end
		issue_valid = 1'b0;
		issue       = '0;
		wait (chk_seen >= issues.size());
		repeat (4) @(negedge clk); // Room for a stray write-back
		$display("%0d tests ok, %0d tests with errors", chk_ok, chk_bad + trace_errs);
		if (chk_bad == 0 && trace_errs == 0 && chk_seen == issues.size()) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin : watchdog
		wait (trace_loaded === 1'b1);
		#((issues.size() * 40 + 16) * 100);
		if (chk_seen < issues.size())
			$display("Timeout: test %0d %s never finished", chk_seen + 1, names[chk_seen]);
		else
			$display("Timeout: run did not reach its end");
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
exe_pkg.sv
exe_alu.sv
exe_muldiv.sv
exe_lsu.sv
exe_ctrl.sv
exe_stage.sv
tb_exe_checker.sv
tb_exe_stage.sv

// File: exe_trace.txt
# op rd we op_a op_b imm pc | expected: data misaligned taken target (all fields hex)
# Target is compared only when taken is 1, data only when we is 1 and misaligned is 0
add   01 1 00000005 00000007 00000000 00000000 0000000c 0 0 00000000
sub   02 1 00000005 00000007 00000000 00000004 fffffffe 0 0 00000000
sll   03 1 00000001 0000001f 00000000 00000008 80000000 0 0 00000000
slt   04 1 ffffffff 00000001 00000000 0000000c 00000001 0 0 00000000
sltu  05 1 ffffffff 00000001 00000000 00000010 00000000 0 0 00000000
sra   06 1 80000000 00000004 00000000 00000014 f8000000 0 0 00000000
xor   07 1 f0f0f0f0 0ff00ff0 00000000 00000018 ff00ff00 0 0 00000000
lui   08 1 00000000 00000000 12345000 0000001c 12345000 0 0 00000000
auipc 09 1 00000000 00000000 00001000 00000100 00001100 0 0 00000000
beq   00 0 00000005 00000005 00000010 00000200 00000000 0 1 00000210
bne   00 0 00000005 00000005 00000010 00000200 00000000 0 0 00000000
blt   00 0 ffffffff 00000001 fffffff0 00000200 00000000 0 1 000001f0
bgeu  00 0 ffffffff 00000001 00000020 00000200 00000000 0 1 00000220
jal   01 1 00000000 00000000 00000400 00000300 00000304 0 1 00000700
jalr  01 1 00001001 00000000 00000004 00000310 00000314 0 1 00001004
mul   0a 1 00000007 fffffffd 00000000 00000000 ffffffeb 0 0 00000000
mulh  0b 1 80000000 80000000 00000000 00000000 40000000 0 0 00000000
mulhu 0c 1 ffffffff ffffffff 00000000 00000000 fffffffe 0 0 00000000
div   0d 1 ffffffec 00000003 00000000 00000000 fffffffa 0 0 00000000
rem   0e 1 ffffffec 00000003 00000000 00000000 fffffffe 0 0 00000000
divu  0f 1 00000064 00000000 00000000 00000000 ffffffff 0 0 00000000
remu  10 1 00000064 00000000 00000000 00000000 00000064 0 0 00000000
div   11 1 80000000 ffffffff 00000000 00000000 80000000 0 0 00000000
sw    00 0 00000040 11223344 00000000 00000000 00000000 0 0 00000000
sb    00 0 00000040 00000085 00000003 00000000 00000000 0 0 00000000
sw    00 0 00000040 55667788 00000004 00000000 00000000 0 0 00000000
sh    00 0 00000040 00009abc 00000006 00000000 00000000 0 0 00000000
lw    12 1 00000040 00000000 00000000 00000000 85223344 0 0 00000000
lb    13 1 00000040 00000000 00000003 00000000 ffffff85 0 0 00000000
lbu   14 1 00000040 00000000 00000003 00000000 00000085 0 0 00000000
lh    15 1 00000040 00000000 00000006 00000000 ffff9abc 0 0 00000000
lhu   16 1 00000040 00000000 00000004 00000000 00007788 0 0 00000000
lh    17 1 00000040 00000000 00000001 00000000 00000000 1 0 00000000
sw    00 0 00000044 deadbeef 00000002 00000000 00000000 1 0 00000000
sh    00 0 00000044 0000ffff 00000001 00000000 00000000 1 0 00000000
lw    18 1 00000044 00000000 00000000 00000000 9abc7788 0 0 00000000
mul   19 1 00000003 00000005 00000000 00000000 0000000f 0 0 00000000
lw    1a 1 00000040 00000000 00000000 00000000 85223344 0 0 00000000
add   1b 1 00000001 00000002 00000000 00000020 00000003 0 0 00000000
sub   1c 1 00000003 00000001 00000000 00000024 00000002 0 0 00000000
